// ==== common/sspi_cmd_pkg.sv ====
/*
  SPI frame protocol: header layout, command codes and data path steering.
  frame_ctl_t uses sspi_regs_pkg::buf_addr_t, so sspi_regs_pkg compiles first.
  Words are 32 bits and travel MSB first in both directions.
*/
package sspi_cmd_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Word and header layout
    ////////////////////////////////////////////////////////////////////////////
    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0]         word_t;
    typedef logic [3:0]                cmd_t;
    typedef logic [$clog2(WORD_W)-1:0] bit_idx_t;

    // Command sits in the top nibble, start address in the low bits
    localparam int CMD_MSB  = 31;
    localparam int CMD_LSB  = 28;
    localparam int ADDR_LSB = 0;

    localparam cmd_t CMD_REG_READ  = 4'h0;
    localparam cmd_t CMD_REG_WRITE = 4'h1;
    localparam cmd_t CMD_BUF_READ  = 4'h2;
    localparam cmd_t CMD_BUF_WRITE = 4'h3;

    ////////////////////////////////////////////////////////////////////////////
    // Frame sequencing and steering
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        IDLE,
        HEADER,
        REG_WR,
        REG_RD,
        BUF_WR,
        BUF_RD,
        IGNORE
    } frame_state_t;

    // Source of the next transmit word
    typedef enum logic [1:0] {
        TX_ZERO,
        TX_REG,
        TX_BUF
    } tx_sel_t;

    typedef struct packed {
        logic                     reg_we;
        logic                     buf_we;
        logic                     tx_load;
        tx_sel_t                  tx_sel;
        sspi_regs_pkg::buf_addr_t addr;     // Register index uses the low bits only
    } frame_ctl_t;

endpackage

// ==== common/sspi_regs_pkg.sv ====
/*
  Register map and mailbox sizing of the SPI slave.
  The mailbox depth is a power of two, so its address wraps naturally.
*/
package sspi_regs_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Register file
    ////////////////////////////////////////////////////////////////////////////
    localparam int REG_COUNT = 4;

    typedef logic [$clog2(REG_COUNT)-1:0] reg_addr_t;

    localparam reg_addr_t REG_CTRL    = 2'd0;
    localparam reg_addr_t REG_SCRATCH = 2'd1;
    localparam reg_addr_t REG_ID      = 2'd2;
    localparam reg_addr_t REG_WCOUNT  = 2'd3;

    // Reset values of the writable registers
    localparam logic [31:0] CTRL_RESET    = 32'h0000_0000;
    localparam logic [31:0] SCRATCH_RESET = 32'h0000_0000;

    // Identity word, reads as ASCII "SPI1"
    localparam logic [31:0] ID_VALUE = 32'h5350_4931;

    // Mailbox write counter, zero-extended on read
    typedef logic [15:0] word_cnt_t;

    ////////////////////////////////////////////////////////////////////////////
    // Mailbox
    ////////////////////////////////////////////////////////////////////////////
    localparam int BUF_DEPTH = 64;

    typedef logic [$clog2(BUF_DEPTH)-1:0] buf_addr_t;

endpackage

// ==== hw/sspi/sspi_bit_counter.sv ====
/*
  Bit and word framing for the SPI slave, clocked by the SPI clock itself.
  A rising ss_n drops any partial word, and the next frame starts at bit 31.
*/
`timescale 1ns/1ps

module sspi_bit_counter (
    input  logic                   sclk,
    input  logic                   rst_n_sclk,
    input  logic                   ss_n,
    output sspi_cmd_pkg::bit_idx_t bit_idx,
    output logic                   word_end,
    output logic                   first_word
);

    sspi_cmd_pkg::bit_idx_t bit_cnt;
    logic                   hdr_done;

    // Number of bits sampled so far in the current word
    always_ff @(posedge sclk or negedge rst_n_sclk) begin
        if (!rst_n_sclk) begin
            bit_cnt <= '0;
        end else if (ss_n) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // Set once the header word is complete, held to the end of the frame
    always_ff @(posedge sclk or negedge rst_n_sclk) begin
        if (!rst_n_sclk) begin
            hdr_done <= 1'b0;
        end else if (ss_n) begin
            hdr_done <= 1'b0;
        end else if (word_end) begin
            hdr_done <= 1'b1;
        end
    end

    // Bits arrive MSB first, so the position counts down
    assign bit_idx    = ~bit_cnt;
    assign word_end   = ~ss_n & (bit_cnt == '1);
    assign first_word = ~hdr_done;

endmodule

// ==== hw/sspi/sspi_frame_fsm.sv ====
/*
  Frame sequencer. The header is decoded on its last bit and steers the data words.
  Strobes are combinational with word_end, so each lands on the edge that
  completes the word. Unknown commands silence the rest of the frame.
*/
`timescale 1ns/1ps

module sspi_frame_fsm (
    input  logic                     sclk,
    input  logic                     rst_n_sclk,
    input  logic                     ss_n,
    input  logic                     word_end,
    input  logic                     first_word,
    input  sspi_cmd_pkg::word_t      rx_word,
    output sspi_cmd_pkg::frame_ctl_t ctl
);

    sspi_cmd_pkg::frame_state_t state;
    sspi_cmd_pkg::frame_state_t state_nxt;
    sspi_regs_pkg::buf_addr_t   addr_q;
    sspi_regs_pkg::buf_addr_t   addr_nxt;
    sspi_cmd_pkg::cmd_t         hdr_cmd;
    sspi_regs_pkg::buf_addr_t   hdr_addr;

    // Header fields, valid while the header's last bit is on mosi
    assign hdr_cmd  = rx_word[sspi_cmd_pkg::CMD_MSB:sspi_cmd_pkg::CMD_LSB];
    assign hdr_addr = rx_word[sspi_cmd_pkg::ADDR_LSB +: $bits(sspi_regs_pkg::buf_addr_t)];

    always_comb begin
        state_nxt  = state;
        addr_nxt   = addr_q;
        ctl        = '0;
        ctl.tx_sel = sspi_cmd_pkg::TX_ZERO;
        ctl.addr   = addr_q;

        case (state)
            sspi_cmd_pkg::IDLE: begin
                state_nxt = sspi_cmd_pkg::HEADER;
            end
            sspi_cmd_pkg::HEADER: begin
                if (word_end && first_word) begin
                    addr_nxt = hdr_addr;
                    case (hdr_cmd)
                        sspi_cmd_pkg::CMD_REG_WRITE: state_nxt = sspi_cmd_pkg::REG_WR;
                        sspi_cmd_pkg::CMD_BUF_WRITE: state_nxt = sspi_cmd_pkg::BUF_WR;
                        sspi_cmd_pkg::CMD_REG_READ: begin
                            // Register reads have no latency, word 1 is the start register
                            state_nxt   = sspi_cmd_pkg::REG_RD;
                            ctl.tx_load = 1'b1;
                            ctl.tx_sel  = sspi_cmd_pkg::TX_REG;
                            ctl.addr    = hdr_addr;
                            addr_nxt    = hdr_addr + 1'b1;
                        end
                        sspi_cmd_pkg::CMD_BUF_READ: begin
                            // Word 1 is a zero filler while the mailbox read is in flight
                            state_nxt   = sspi_cmd_pkg::BUF_RD;
                            ctl.tx_load = 1'b1;
                        end
                        default: state_nxt = sspi_cmd_pkg::IGNORE;
                    endcase
                end
            end
            sspi_cmd_pkg::REG_WR: begin
                ctl.reg_we = word_end;
                if (word_end) addr_nxt = addr_q + 1'b1;
            end
            sspi_cmd_pkg::BUF_WR: begin
                ctl.buf_we = word_end;
                if (word_end) addr_nxt = addr_q + 1'b1;
            end
            sspi_cmd_pkg::REG_RD: begin
                ctl.tx_load = word_end;
                ctl.tx_sel  = sspi_cmd_pkg::TX_REG;
                if (word_end) addr_nxt = addr_q + 1'b1;
            end
            sspi_cmd_pkg::BUF_RD: begin
                // Mailbox output already holds the word read during this one
                ctl.tx_load = word_end;
                ctl.tx_sel  = sspi_cmd_pkg::TX_BUF;
                if (word_end) addr_nxt = addr_q + 1'b1;
            end
            default: begin
                // IGNORE: zero fill of the shifter keeps miso low
            end
        endcase

        // Deselect ends the frame from any state
        if (ss_n) begin
            state_nxt = sspi_cmd_pkg::IDLE;
            addr_nxt  = '0;
        end
    end

    always_ff @(posedge sclk or negedge rst_n_sclk) begin
        if (!rst_n_sclk) begin
            state  <= sspi_cmd_pkg::IDLE;
            addr_q <= '0;
        end else begin
            state  <= state_nxt;
            addr_q <= addr_nxt;
        end
    end

endmodule

// ==== hw/sspi/sspi_shifter.sv ====
/*
  Serial data path. mosi is sampled on the rising edge, miso changes on the falling edge.
  rx_word includes the bit on mosi now, so it is complete on the word_end edge.
  miso idles high while ss_n is high.
*/
`timescale 1ns/1ps

module sspi_shifter (
    input  logic                     sclk,
    input  logic                     rst_n_sclk,
    input  logic                     ss_n,
    input  logic                     mosi,
    input  sspi_cmd_pkg::frame_ctl_t ctl,
    input  sspi_cmd_pkg::word_t      reg_rdata,
    input  sspi_cmd_pkg::word_t      buf_rdata,
    output sspi_cmd_pkg::word_t      rx_word,
    output logic                     miso
);

    logic [$bits(sspi_cmd_pkg::word_t)-2:0] rx_sr;
    sspi_cmd_pkg::word_t                    tx_sr;
    sspi_cmd_pkg::word_t                    tx_src;
    logic                                   miso_q;

    ////////////////////////////////////////////////////////////////////////////
    // Receive
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge sclk) begin
        if (!ss_n) begin
            rx_sr <= rx_word[$bits(rx_sr)-1:0];
        end
    end

    assign rx_word = {rx_sr, mosi};

    ////////////////////////////////////////////////////////////////////////////
    // Transmit
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (ctl.tx_sel)
            sspi_cmd_pkg::TX_REG: tx_src = reg_rdata;
            sspi_cmd_pkg::TX_BUF: tx_src = buf_rdata;
            default:              tx_src = '0;
        endcase
    end

    // Cleared between frames so the header phase shifts out zeros
    always_ff @(posedge sclk or negedge rst_n_sclk) begin
        if (!rst_n_sclk) begin
            tx_sr <= '0;
        end else if (ss_n) begin
            tx_sr <= '0;
        end else if (ctl.tx_load) begin
            tx_sr <= tx_src;
        end else begin
            tx_sr <= {tx_sr[$bits(tx_sr)-2:0], 1'b0};
        end
    end

    // Half a cycle of setup for the master's next rising edge
    always_ff @(negedge sclk or negedge rst_n_sclk) begin
        if (!rst_n_sclk) begin
            miso_q <= 1'b1;
        end else if (ss_n) begin
            miso_q <= 1'b1;
        end else begin
            miso_q <= tx_sr[$bits(tx_sr)-1];
        end
    end

    assign miso = miso_q | ss_n;

endmodule

// ==== hw/sspi_csr_regs.sv ====
/*
  Control register file. CTRL and SCRATCH are read-write; ID and WCOUNT ignore writes.
  WCOUNT counts mailbox word writes and wraps at 16 bits.
*/
`timescale 1ns/1ps

module sspi_csr_regs (
    input  logic                     sclk,
    input  logic                     rst_n_sclk,
    input  sspi_cmd_pkg::frame_ctl_t ctl,
    input  sspi_cmd_pkg::word_t      rx_word,
    output sspi_cmd_pkg::word_t      reg_rdata,
    output sspi_cmd_pkg::word_t      ctrl
);

    sspi_cmd_pkg::word_t      ctrl_q;
    sspi_cmd_pkg::word_t      scratch_q;
    sspi_regs_pkg::word_cnt_t wcount_q;
    sspi_regs_pkg::reg_addr_t reg_idx;

    // Burst index wraps within the register file
    assign reg_idx = ctl.addr[$bits(sspi_regs_pkg::reg_addr_t)-1:0];

    always_ff @(posedge sclk or negedge rst_n_sclk) begin
        if (!rst_n_sclk) begin
            ctrl_q    <= sspi_regs_pkg::CTRL_RESET;
            scratch_q <= sspi_regs_pkg::SCRATCH_RESET;
        end else if (ctl.reg_we) begin
            case (reg_idx)
                sspi_regs_pkg::REG_CTRL:    ctrl_q    <= rx_word;
                sspi_regs_pkg::REG_SCRATCH: scratch_q <= rx_word;
                default: begin
                    // Read-only entries
                end
            endcase
        end
    end

    always_ff @(posedge sclk or negedge rst_n_sclk) begin
        if (!rst_n_sclk) begin
            wcount_q <= '0;
        end else if (ctl.buf_we) begin
            wcount_q <= wcount_q + 1'b1;
        end
    end

    always_comb begin
        case (reg_idx)
            sspi_regs_pkg::REG_CTRL:    reg_rdata = ctrl_q;
            sspi_regs_pkg::REG_SCRATCH: reg_rdata = scratch_q;
            sspi_regs_pkg::REG_ID:      reg_rdata = sspi_regs_pkg::ID_VALUE;
            default:                    reg_rdata = sspi_cmd_pkg::word_t'(wcount_q);
        endcase
    end

    assign ctrl = ctrl_q;

endmodule

// ==== hw/sspi_mailbox_ram.sv ====
/*
  Mailbox word RAM, one write port and one registered read port on the same address.
  Contents are undefined until written. A read of the word being written returns
  the old data.
*/
`timescale 1ns/1ps

module sspi_mailbox_ram (
    input  logic                     sclk,
    input  sspi_cmd_pkg::frame_ctl_t ctl,
    input  sspi_cmd_pkg::word_t      rx_word,
    output sspi_cmd_pkg::word_t      buf_rdata
);

    sspi_cmd_pkg::word_t mem [sspi_regs_pkg::BUF_DEPTH];

    ////////////////////////////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge sclk) begin
        if (ctl.buf_we) begin
            mem[ctl.addr] <= rx_word;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read port
    ////////////////////////////////////////////////////////////////////////////

    // One cycle of latency, hidden by the sequencer running one word ahead
    always_ff @(posedge sclk) begin
        buf_rdata <= mem[ctl.addr];
    end

endmodule

// ==== hw/sspi_top.sv ====
/*
  SPI slave bridge to a register file and a 64-word mailbox, all on the SPI clock.
  sclk need only toggle while ss_n is low, plus two edges after each frame.
  ctrl mirrors the CTRL register.
*/
`timescale 1ns/1ps

module sspi_top (
    input  logic                sclk,
    input  logic                rst_n_sclk,
    input  logic                ss_n,
    input  logic                mosi,
    output logic                miso,
    output sspi_cmd_pkg::word_t ctrl
);

    logic                     word_end;
    logic                     first_word;
    sspi_cmd_pkg::word_t      rx_word;
    sspi_cmd_pkg::word_t      reg_rdata;
    sspi_cmd_pkg::word_t      buf_rdata;
    sspi_cmd_pkg::frame_ctl_t ctl;

    // Bit position is not needed by the frame logic
    sspi_bit_counter u_bit_counter (
        .sclk       (sclk),
        .rst_n_sclk (rst_n_sclk),
        .ss_n       (ss_n),
        .bit_idx    (),
        .word_end   (word_end),
        .first_word (first_word)
    );

    sspi_frame_fsm u_frame_fsm (
        .sclk       (sclk),
        .rst_n_sclk (rst_n_sclk),
        .ss_n       (ss_n),
        .word_end   (word_end),
        .first_word (first_word),
        .rx_word    (rx_word),
        .ctl        (ctl)
    );

    sspi_shifter u_shifter (
        .sclk       (sclk),
        .rst_n_sclk (rst_n_sclk),
        .ss_n       (ss_n),
        .mosi       (mosi),
        .ctl        (ctl),
        .reg_rdata  (reg_rdata),
        .buf_rdata  (buf_rdata),
        .rx_word    (rx_word),
        .miso       (miso)
    );

    sspi_csr_regs u_csr_regs (
        .sclk       (sclk),
        .rst_n_sclk (rst_n_sclk),
        .ctl        (ctl),
        .rx_word    (rx_word),
        .reg_rdata  (reg_rdata),
        .ctrl       (ctrl)
    );

    sspi_mailbox_ram u_mailbox_ram (
        .sclk       (sclk),
        .ctl        (ctl),
        .rx_word    (rx_word),
        .buf_rdata  (buf_rdata)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the SPI slave testbench, from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module sspi_tb -f verilog.f -Mdir obj_dir -o sspi_sim; then
    echo "Verilator build failed"
    exit 1
fi

# Raised error limit lets the run reach the testbench verdict after assertion errors
if ! out=$(./obj_dir/sspi_sim +verilator+error+limit+1000); then
    printf '%s\n' "$out"
    echo "simulation exited with an error status"
    exit 1
fi
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Test OK"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== tb/sspi_checker.sv ====
/*
  Protocol assertions on the steering outputs of sspi_frame_fsm, bound to every instance.
  Checked only out of reset.
*/
`timescale 1ns/1ps

module sspi_checker (
    input logic                     sclk,
    input logic                     rst_n_sclk,
    input logic                     ss_n,
    input sspi_cmd_pkg::frame_ctl_t ctl
);

    int fail_count = 0;

    // A frame targets either the registers or the mailbox
    a_one_target: assert property (@(posedge sclk) disable iff (!rst_n_sclk)
        !(ctl.reg_we && ctl.buf_we))
        else begin
            $error("reg_we and buf_we high together");
            fail_count++;
        end

    // Deselected slave stays quiet
    a_quiet_deselected: assert property (@(posedge sclk) disable iff (!rst_n_sclk)
        ss_n |-> !(ctl.reg_we || ctl.buf_we || ctl.tx_load))
        else begin
            $error("strobe or tx_load while ss_n is high");
            fail_count++;
        end

    a_single_strobe: assert property (@(posedge sclk) disable iff (!rst_n_sclk)
        (ctl.reg_we || ctl.buf_we) |=> !(ctl.reg_we || ctl.buf_we))
        else begin
            $error("write strobe longer than one cycle");
            fail_count++;
        end

endmodule

bind sspi_frame_fsm sspi_checker u_checker (
    .sclk       (sclk),
    .rst_n_sclk (rst_n_sclk),
    .ss_n       (ss_n),
    .ctl        (ctl)
);

// ==== tb/sspi_tb.sv ====
/*
  Testbench for the SPI slave bridge. The master runs whole frames on the free-running sclk.
  A model of the registers and the mailbox predicts every word that is read back.
  Mailbox reads are checked only after the first full 64-word write.
*/
`timescale 1ns/1ps

module sspi_tb;

    localparam int MAX_WORDS    = 72;
    localparam int IDLE_TIMEOUT = 8;

    logic                sclk = 1'b0;
    logic                rst_n_sclk;
    logic                ss_n;
    logic                mosi;
    logic                miso;
    sspi_cmd_pkg::word_t ctrl;

    // Frame buffers with the header in entry 0
    sspi_cmd_pkg::word_t tx_words [MAX_WORDS];
    sspi_cmd_pkg::word_t rx_words [MAX_WORDS];

    // Reference model
    sspi_cmd_pkg::word_t      model_regs [sspi_regs_pkg::REG_COUNT];
    sspi_cmd_pkg::word_t      model_buf [sspi_regs_pkg::BUF_DEPTH];
    sspi_regs_pkg::word_cnt_t model_wcount;

    logic [31:0] lcg_state;
    int          checks;
    int          errors;
    int          tests;
    int          tests_failed;
    int          test_base;
    int          assert_fails;
    string       test_name;

    sspi_top dut (
        .sclk       (sclk),
        .rst_n_sclk (rst_n_sclk),
        .ss_n       (ss_n),
        .mosi       (mosi),
        .miso       (miso),
        .ctrl       (ctrl)
    );

    always #4 sclk = ~sclk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // The low LCG bits have short periods so only the upper bits are used
    function automatic int rand_below(input int n);
        return int'((lcg_next() >> 8) % n);
    endfunction

    function automatic sspi_cmd_pkg::word_t make_header(input sspi_cmd_pkg::cmd_t cmd,
                                                        input sspi_regs_pkg::buf_addr_t addr);
        sspi_cmd_pkg::word_t hdr;
        hdr = '0;
        hdr[sspi_cmd_pkg::CMD_MSB:sspi_cmd_pkg::CMD_LSB] = cmd;
        hdr[sspi_cmd_pkg::ADDR_LSB +: $bits(sspi_regs_pkg::buf_addr_t)] = addr;
        return hdr;
    endfunction

    function automatic sspi_cmd_pkg::word_t model_read(input sspi_cmd_pkg::cmd_t cmd,
                                                       input sspi_regs_pkg::buf_addr_t addr);
        sspi_regs_pkg::reg_addr_t idx;
        idx = addr[1:0];
        if (cmd == sspi_cmd_pkg::CMD_BUF_READ) return model_buf[addr];
        if (idx == sspi_regs_pkg::REG_ID) return sspi_regs_pkg::ID_VALUE;
        if (idx == sspi_regs_pkg::REG_WCOUNT) return sspi_cmd_pkg::word_t'(model_wcount);
        return model_regs[idx];
    endfunction

    task automatic check_word(input string name, input sspi_cmd_pkg::word_t exp,
                              input sspi_cmd_pkg::word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error at %0t ns: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_ctrl(input sspi_cmd_pkg::word_t exp, input sspi_cmd_pkg::word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error at %0t ns: ctrl expected %h got %h", $time, exp, act);
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error at %0t ns: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // Waits for miso to return high after ss_n rises and then holds the gap between frames
    task automatic wait_miso_idle();
        int n;
        n = 0;
        while (miso !== 1'b1 && n < IDLE_TIMEOUT) begin
            @(posedge sclk);
            n++;
        end
        if (miso !== 1'b1) begin
            $display("timeout: miso did not return high within %0d cycles", IDLE_TIMEOUT);
            $display("Test FAILED");
            $finish;
        end else begin
            repeat (2) @(posedge sclk);
        end
    endtask

    // Header, n data words from tx_words, then extra_bits of a cut-off word
    task automatic run_frame(input sspi_cmd_pkg::word_t header, input int n, input int extra_bits);
        int total;
        int w;
        int b;
        total = 32 * (n + 1) + extra_bits;
        tx_words[0] = header;
        @(posedge sclk);
        ss_n <= 1'b0;
        mosi <= header[31];
        for (int i = 0; i < total; i++) begin
            @(posedge sclk);
            w = i / 32;
            b = 31 - i % 32;
            rx_words[w][b] = miso;
            if (i + 1 < total) begin
                mosi <= tx_words[(i + 1) / 32][31 - (i + 1) % 32];
            end else begin
                ss_n <= 1'b1;
                mosi <= 1'b0;
            end
        end
        wait_miso_idle();
    endtask

    task automatic write_burst(input sspi_cmd_pkg::cmd_t cmd,
                               input sspi_regs_pkg::buf_addr_t start,
                               input int n, input int extra_bits);
        sspi_regs_pkg::buf_addr_t addr;
        for (int k = 1; k <= n + 1; k++) tx_words[k] = lcg_next();
        run_frame(make_header(cmd, start), n, extra_bits);
        addr = start;
        for (int k = 1; k <= n; k++) begin
            if (cmd == sspi_cmd_pkg::CMD_BUF_WRITE) begin
                model_buf[addr] = tx_words[k];
                model_wcount = model_wcount + 1'b1;
            end else if (addr[1:0] == sspi_regs_pkg::REG_CTRL ||
                         addr[1:0] == sspi_regs_pkg::REG_SCRATCH) begin
                model_regs[addr[1:0]] = tx_words[k];
            end
            addr = addr + 1'b1;
        end
    endtask

    task automatic read_check(input sspi_cmd_pkg::cmd_t cmd,
                              input sspi_regs_pkg::buf_addr_t start,
                              input int n);
        sspi_regs_pkg::buf_addr_t addr;
        bit                       is_buf;
        is_buf = (cmd == sspi_cmd_pkg::CMD_BUF_READ);
        run_frame(make_header(cmd, start), n, 0);
        addr = start;
        // Buffer reads lead with one filler word
        if (is_buf) check_word("mailbox filler", '0, rx_words[1]);
        for (int k = is_buf ? 2 : 1; k <= n; k++) begin
            check_word(is_buf ? $sformatf("mailbox[%0d]", addr) : $sformatf("reg[%0d]", addr[1:0]),
                       model_read(cmd, addr), rx_words[k]);
            addr = addr + 1'b1;
        end
    endtask

    task automatic finish_test();
        tests++;
        if (errors == test_base) begin
            $display("test %0d %s: passed", tests, test_name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests, test_name, errors - test_base);
        end
        test_base = errors;
    endtask

    initial begin
        sspi_regs_pkg::buf_addr_t start;
        sspi_cmd_pkg::cmd_t       bad_cmd;
        lcg_state    = 32'd28;
        checks       = 0;
        errors       = 0;
        tests        = 0;
        tests_failed = 0;
        test_base    = 0;
        model_wcount = '0;
        for (int i = 0; i < sspi_regs_pkg::REG_COUNT; i++) model_regs[i] = '0;
        rst_n_sclk = 1'b0;
        ss_n       = 1'b1;
        mosi       = 1'b0;
        repeat (16) @(posedge sclk);
        rst_n_sclk <= 1'b1;
        wait_miso_idle();

        test_name = "reset values";
        check_level("miso", 1'b1, miso);
        check_ctrl('0, ctrl);
        read_check(sspi_cmd_pkg::CMD_REG_READ,
                   sspi_regs_pkg::buf_addr_t'(sspi_regs_pkg::REG_ID), 2);
        finish_test();

        test_name = "register bursts";
        for (int r = 0; r < 3; r++) begin
            write_burst(sspi_cmd_pkg::CMD_REG_WRITE, sspi_regs_pkg::buf_addr_t'(rand_below(4)),
                        4 + rand_below(5), 0);
            check_ctrl(model_regs[sspi_regs_pkg::REG_CTRL], ctrl);
            read_check(sspi_cmd_pkg::CMD_REG_READ, sspi_regs_pkg::buf_addr_t'(rand_below(4)),
                       4 + rand_below(5));
        end
        finish_test();

        test_name = "mailbox bursts";
        write_burst(sspi_cmd_pkg::CMD_BUF_WRITE, sspi_regs_pkg::buf_addr_t'(rand_below(64)),
                    64, 0);
        for (int r = 0; r < 4; r++) begin
            write_burst(sspi_cmd_pkg::CMD_BUF_WRITE, sspi_regs_pkg::buf_addr_t'(rand_below(64)),
                        1 + rand_below(20), 0);
            read_check(sspi_cmd_pkg::CMD_BUF_READ, sspi_regs_pkg::buf_addr_t'(rand_below(64)),
                       24 + rand_below(40));
        end
        read_check(sspi_cmd_pkg::CMD_BUF_READ, sspi_regs_pkg::buf_addr_t'(60), 10);
        finish_test();

        test_name = "write count";
        read_check(sspi_cmd_pkg::CMD_REG_READ,
                   sspi_regs_pkg::buf_addr_t'(sspi_regs_pkg::REG_WCOUNT), 1);
        finish_test();

        test_name = "unknown command";
        bad_cmd = sspi_cmd_pkg::cmd_t'(4 + rand_below(12));
        for (int k = 1; k <= 4; k++) tx_words[k] = lcg_next();
        run_frame(make_header(bad_cmd, sspi_regs_pkg::buf_addr_t'(rand_below(64))), 4, 0);
        for (int k = 1; k <= 4; k++) check_word("ignored frame word", '0, rx_words[k]);
        read_check(sspi_cmd_pkg::CMD_REG_READ, '0, 4);
        read_check(sspi_cmd_pkg::CMD_BUF_READ, '0, 65);
        check_ctrl(model_regs[sspi_regs_pkg::REG_CTRL], ctrl);
        finish_test();

        test_name = "cut-off write";
        start = sspi_regs_pkg::buf_addr_t'(rand_below(64));
        write_burst(sspi_cmd_pkg::CMD_BUF_WRITE, start, 3, 1 + rand_below(31));
        read_check(sspi_cmd_pkg::CMD_BUF_READ, start, 6);
        read_check(sspi_cmd_pkg::CMD_REG_READ,
                   sspi_regs_pkg::buf_addr_t'(sspi_regs_pkg::REG_WCOUNT), 1);
        finish_test();

        assert_fails = dut.u_frame_fsm.u_checker.fail_count;
        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests, tests_failed, checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
common/sspi_regs_pkg.sv
common/sspi_cmd_pkg.sv
hw/sspi/sspi_bit_counter.sv
hw/sspi/sspi_frame_fsm.sv
hw/sspi/sspi_shifter.sv
hw/sspi_csr_regs.sv
hw/sspi_mailbox_ram.sv
hw/sspi_top.sv
tb/sspi_checker.sv
tb/sspi_tb.sv
